/* hw/noc_pkg.sv */
/*
 * Shared definitions for the three-port look-ahead wormhole router
 * Sizes, port and direction encodings, flit layout and link structs
 */
package noc_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    // Flit bits without the head/tail preamble
    localparam int unsigned DataWidth = 32;
    // Full flit width as seen on a link
    localparam int unsigned FlitWidth = DataWidth + 2;
    // Entries in each input FIFO
    localparam int unsigned QueueDepth = 4;
    // East, West and Local
    localparam int unsigned PortCount = 3;

    //////////////////////////////////////////////////
    // Ports and directions
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        PORT_EAST  = 2'd0,
        PORT_WEST  = 2'd1,
        PORT_LOCAL = 2'd2
    } port_e;

    // One-hot output request, bit i selects port i
    typedef logic [PortCount-1:0] direction_t;

    // Zero means the flit requests no output
    localparam direction_t DirNone  = 3'b000;
    localparam direction_t DirEast  = 3'b001;
    localparam direction_t DirWest  = 3'b010;
    localparam direction_t DirLocal = 3'b100;

    //////////////////////////////////////////////////
    // Flit layout
    //////////////////////////////////////////////////

    // Both bits set marks a single-flit packet
    typedef struct packed {
        logic head;
        logic tail;
    } preamble_t;

    // Mesh coordinates, y travels along but this row never routes on it
    typedef struct packed {
        logic [2:0] x;
        logic [2:0] y;
    } xy_t;

    typedef enum logic [1:0] {
        MSG_REQUEST   = 2'd0,
        MSG_RESPONSE  = 2'd1,
        MSG_INTERRUPT = 2'd2,
        MSG_DEBUG     = 2'd3
    } message_e;

    // Header bits left over once the routing information is placed
    localparam int unsigned ReservedWidth =
        DataWidth - 2 * $bits(xy_t) - $bits(message_e) - $bits(direction_t);

    typedef struct packed {
        preamble_t                preamble;
        xy_t                      source;
        xy_t                      destination;
        message_e                 message;
        logic [ReservedWidth-1:0] reserved;
        // Output to take at the router receiving this flit
        direction_t               routing;
    } header_t;

    // Same bits read as a header or as raw payload
    typedef union packed {
        header_t              header;
        logic [FlitWidth-1:0] raw;
    } flit_t;

    //////////////////////////////////////////////////
    // Link and internal transport
    //////////////////////////////////////////////////

    // High is_void means the link carries no flit this cycle
    typedef struct packed {
        flit_t flit;
        logic  is_void;
    } link_t;

    // Head of an input queue as offered to every output port
    typedef struct packed {
        flit_t      flit;
        logic       valid;
        direction_t request;
        direction_t next_hop;
    } fwd_t;

endpackage

/* hw/router_fifo.sv */
/*
 * Input flit FIFO
 * Circular buffer with occupancy count, passes a flit through in the same cycle when empty
 */
`timescale 1ns/1ps

module router_fifo #(
    parameter int unsigned Depth = 4,
    parameter int unsigned Width = 34
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr_i,
    input  logic [Width-1:0] data_i,
    input  logic             rd_i,
    output logic [Width-1:0] data_o,
    output logic             empty_o,
    output logic             full_o
);

    logic [Width-1:0]           mem_q [Depth];
    logic [$clog2(Depth)-1:0]   wr_ptr_q;
    logic [$clog2(Depth)-1:0]   rd_ptr_q;
    logic [$clog2(Depth+1)-1:0] count_q;
    logic                       push;
    logic                       pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == Depth);

    // A read on an empty queue takes the bypassed flit, nothing is stored
    assign push = wr_i & ~(empty_o & rd_i);
    assign pop  = rd_i & ~empty_o;

    // Bypass path when nothing is queued
    assign data_o = empty_o ? data_i : mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == Depth - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == Depth - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            // Occupancy only moves when exactly one side acts
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Upstream must honour the stop level derived from full_o
    a_no_write_full: assert property (@(posedge clk) disable iff (rst) full_o |-> !wr_i)
        else $error("router_fifo: write while full");

    // Output ports only pop what they saw as a valid head
    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        (empty_o && rd_i) |-> wr_i)
        else $error("router_fifo: read while empty without bypass");

endmodule

/* hw/router_arbiter.sv */
/*
 * Round-robin output arbiter
 * Grant is held from the head of a worm until its tail has been forwarded
 */
`timescale 1ns/1ps

module router_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [noc_pkg::PortCount-1:0] req_i,
    input  logic                          head_i,
    input  logic                          tail_i,
    output logic [noc_pkg::PortCount-1:0] grant_o,
    output logic                          grant_valid_o
);
    import noc_pkg::*;

    direction_t ptr_q;
    direction_t held_q;
    logic       lock_q;
    direction_t upper_req;
    direction_t rr_grant;

    // Requests at or above the pointer go first, the rest wrap around
    assign upper_req = req_i & ~(ptr_q - 1'b1);

    // Lowest set bit of the chosen group
    assign rr_grant = (upper_req != '0) ? (upper_req & (~upper_req + 1'b1))
                                        : (req_i & (~req_i + 1'b1));

    assign grant_o       = lock_q ? held_q : rr_grant;
    assign grant_valid_o = |grant_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q  <= DirEast;
            lock_q <= 1'b0;
        end else if (tail_i) begin
            // Worm done, next in line is the port after the winner
            lock_q <= 1'b0;
            ptr_q  <= {grant_o[PortCount-2:0], grant_o[PortCount-1]};
        end else if (head_i) begin
            lock_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (head_i) begin
            held_q <= grant_o;
        end
    end

    // A held grant must stay on an input that still requests this output
    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant_o) && ((grant_o & ~req_i) == '0))
        else $error("router_arbiter: grant %b is not one-hot or has no request", grant_o);

endmodule

/* hw/router_input_port.sv */
/*
 * Router input port
 * Buffers link flits, holds the worm's request and computes the next-hop route
 */
`timescale 1ns/1ps

module router_input_port #(
    parameter noc_pkg::port_e InPort = noc_pkg::PORT_EAST
) (
    input  logic           clk,
    input  logic           rst,
    input  noc_pkg::link_t link_i,
    input  noc_pkg::xy_t   position_i,
    input  logic           rd_i,
    output noc_pkg::fwd_t  fwd_o,
    output logic           stop_o
);
    import noc_pkg::*;

    flit_t      head_flit;
    logic       wr;
    logic       empty;
    logic       full;
    logic       valid;
    logic       valid_head;
    direction_t held_req_q;
    direction_t cur_req;
    direction_t next_hop;
    logic [2:0] next_x;

    //////////////////////////////////////////////////
    // Buffering
    //////////////////////////////////////////////////

    // A flit is taken only while stop_o is low
    // Otherwise the sender keeps presenting it
    assign wr = ~link_i.is_void & ~full;

    router_fifo #(
        .Depth(QueueDepth),
        .Width(FlitWidth)
    ) i_fifo (
        .clk,
        .rst,
        .wr_i   (wr),
        .data_i (link_i.flit),
        .rd_i,
        .data_o (head_flit),
        .empty_o(empty),
        .full_o (full)
    );

    // Head is real if queued or bypassing this cycle
    assign valid      = ~empty | wr;
    assign valid_head = valid & head_flit.header.preamble.head;
    assign stop_o     = full;

    //////////////////////////////////////////////////
    // Routing request
    //////////////////////////////////////////////////

    // Body flits carry no route, so the head's request is kept for the worm
    always_ff @(posedge clk) begin
        if (rst) begin
            held_req_q <= DirNone;
        end else if (rd_i && head_flit.header.preamble.tail) begin
            held_req_q <= DirNone;
        end else if (valid_head) begin
            held_req_q <= head_flit.header.routing;
        end
    end

    assign cur_req = valid_head ? head_flit.header.routing : held_req_q;

    // Look-ahead: decide the output the neighbour will use
    always_comb begin
        next_x   = position_i.x;
        next_hop = DirNone;
        if (cur_req[PORT_EAST]) begin
            next_x = position_i.x + 3'd1;
        end else if (cur_req[PORT_WEST]) begin
            next_x = position_i.x - 3'd1;
        end
        // Local delivery ends the route here
        if (cur_req[PORT_EAST] || cur_req[PORT_WEST]) begin
            if (head_flit.header.destination.x == next_x) begin
                next_hop = DirLocal;
            end else if (head_flit.header.destination.x > next_x) begin
                next_hop = DirEast;
            end else begin
                next_hop = DirWest;
            end
        end
    end

    assign fwd_o.flit     = head_flit;
    assign fwd_o.valid    = valid;
    assign fwd_o.request  = cur_req;
    assign fwd_o.next_hop = next_hop;

    // Neighbour computed the route, it must never send a flit back
    a_no_u_turn: assert property (@(posedge clk) disable iff (rst)
        valid_head |-> !head_flit.header.routing[InPort])
        else $error("router_input_port: head requests its own port %0d", InPort);

endmodule

/* hw/router_output_port.sv */
/*
 * Router output port
 * Worm FSM, crossbar select, look-ahead route insertion and registered link output
 */
`timescale 1ns/1ps

module router_output_port #(
    parameter noc_pkg::port_e OutPort = noc_pkg::PORT_EAST
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  noc_pkg::fwd_t [noc_pkg::PortCount-1:0] fwd_i,
    input  logic                                   stop_i,
    output logic [noc_pkg::PortCount-1:0]          rd_o,
    output noc_pkg::link_t                         link_o
);
    import noc_pkg::*;

    typedef enum logic {
        ST_HEAD = 1'b0,
        ST_BODY = 1'b1
    } state_e;

    state_e     state_q;
    direction_t req;
    direction_t grant;
    logic       grant_valid;
    direction_t saved_sel_q;
    direction_t sel;
    flit_t      sel_flit;
    logic       sel_valid;
    direction_t sel_next_hop;
    flit_t      out_flit;
    logic       fwd_go;
    logic       head_xfer;
    logic       tail_xfer;
    flit_t      flit_q;
    logic       void_q;

    //////////////////////////////////////////////////
    // Arbitration
    //////////////////////////////////////////////////

    // One request bit per input, taken from its request for this port
    always_comb begin
        for (int j = 0; j < PortCount; j++) begin
            req[j] = fwd_i[j].request[OutPort];
        end
    end

    router_arbiter i_arbiter (
        .clk,
        .rst,
        .req_i        (req),
        .head_i       (head_xfer),
        .tail_i       (tail_xfer),
        .grant_o      (grant),
        .grant_valid_o(grant_valid)
    );

    //////////////////////////////////////////////////
    // Crossbar
    //////////////////////////////////////////////////

    // Body flits follow the input that won the head
    assign sel = (state_q == ST_HEAD) ? grant : saved_sel_q;

    always_comb begin
        sel_flit     = '0;
        sel_valid    = 1'b0;
        sel_next_hop = DirNone;
        for (int j = 0; j < PortCount; j++) begin
            if (sel[j]) begin
                sel_flit     = fwd_i[j].flit;
                sel_valid    = fwd_i[j].valid;
                sel_next_hop = fwd_i[j].next_hop;
            end
        end
    end

    // Head leaves with the route for the next router
    always_comb begin
        out_flit = sel_flit;
        if (state_q == ST_HEAD) begin
            out_flit.header.routing = sel_next_hop;
        end
    end

    // Nothing moves while downstream says stop
    assign fwd_go    = sel_valid & ~stop_i;
    assign rd_o      = fwd_go ? sel : DirNone;
    assign head_xfer = fwd_go & sel_flit.header.preamble.head;
    assign tail_xfer = fwd_go & sel_flit.header.preamble.tail;

    //////////////////////////////////////////////////
    // Worm FSM and link register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ST_HEAD;
            saved_sel_q <= DirNone;
        end else begin
            case (state_q)
                ST_HEAD: begin
                    if (grant_valid && fwd_go) begin
                        saved_sel_q <= grant;
                        // Single-flit packets never leave ST_HEAD
                        if (!sel_flit.header.preamble.tail) begin
                            state_q <= ST_BODY;
                        end
                    end
                end
                ST_BODY: begin
                    if (tail_xfer) begin
                        state_q <= ST_HEAD;
                    end
                end
                default: state_q <= ST_HEAD;
            endcase
        end
    end

    // Link flit is held as long as stop_i stays high
    always_ff @(posedge clk) begin
        if (rst) begin
            void_q <= 1'b1;
        end else if (!stop_i) begin
            void_q <= ~fwd_go;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_go) begin
            flit_q <= out_flit;
        end
    end

    assign link_o.flit    = flit_q;
    assign link_o.is_void = void_q;

    // A worm must start with a head flit from its input queue
    a_head_first: assert property (@(posedge clk) disable iff (rst)
        (state_q == ST_HEAD) && fwd_go |-> sel_flit.header.preamble.head)
        else $error("router_output_port %0d: non-head flit forwarded in ST_HEAD", OutPort);

endmodule

/* hw/lookahead_router.sv */
/*
 * Three-port look-ahead wormhole router for one mesh row
 * Connects the East, West and Local input ports to the matching output ports
 */
`timescale 1ns/1ps

module lookahead_router (
    input  logic                                    clk,
    input  logic                                    rst,
    input  noc_pkg::xy_t                            position_i,
    input  noc_pkg::link_t [noc_pkg::PortCount-1:0] link_i,
    input  logic [noc_pkg::PortCount-1:0]           stop_i,
    output noc_pkg::link_t [noc_pkg::PortCount-1:0] link_o,
    output logic [noc_pkg::PortCount-1:0]           stop_o
);
    import noc_pkg::*;

    // Queue heads offered by each input to every output
    fwd_t [PortCount-1:0] fwd;

    // Read strobes indexed as [output][input]
    logic [PortCount-1:0][PortCount-1:0] rd;

    // Pop pulse seen by each input
    logic [PortCount-1:0] rd_in;

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////

    for (genvar g_in = 0; g_in < PortCount; g_in++) begin : gen_input
        // At most one output reads a given input at a time
        assign rd_in[g_in] = rd[PORT_EAST][g_in] | rd[PORT_WEST][g_in] | rd[PORT_LOCAL][g_in];

        router_input_port #(
            .InPort(port_e'(g_in))
        ) i_input (
            .clk,
            .rst,
            .link_i    (link_i[g_in]),
            .position_i,
            .rd_i      (rd_in[g_in]),
            .fwd_o     (fwd[g_in]),
            .stop_o    (stop_o[g_in])
        );
    end

    //////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////

    for (genvar g_out = 0; g_out < PortCount; g_out++) begin : gen_output
        router_output_port #(
            .OutPort(port_e'(g_out))
        ) i_output (
            .clk,
            .rst,
            .fwd_i (fwd),
            .stop_i(stop_i[g_out]),
            .rd_o  (rd[g_out]),
            .link_o(link_o[g_out])
        );
    end

endmodule

/* dv/router_tb.sv */
/*
 * Testbench for the look-ahead wormhole router
 * Table-driven packets, per-output capture and in-order flit comparison
 */
`timescale 1ns/1ps

module router_tb;
    import noc_pkg::*;

    localparam int NumEntries    = 8;
    localparam int NumTests      = 5;
    localparam int TimeoutCycles = 200;
    localparam logic [31:0] LcgSeed = 32'h5496_f7cd;

    // One packet, tests with several entries inject them together
    typedef struct packed {
        logic [3:0]  test_id;
        port_e       in_port;
        logic [2:0]  dest_x;
        logic [3:0]  flit_count;
        logic [31:0] seed;
        logic [2:0]  stop_mask;
        logic [7:0]  stop_cycles;
        port_e       out_port;
        direction_t  exp_routing;
        logic        check_lat;
        logic        expect_stop;
    } stim_t;

    typedef struct packed {
        flit_t flit;
        port_e src;
        logic  check_lat;
    } expect_t;

    typedef struct packed {
        flit_t       flit;
        logic [31:0] cycle;
    } capture_t;

    logic                  clk;
    logic                  rst = 1'b1;
    // Router sits at x = 3 of the row
    xy_t                   position = {3'd3, 3'd1};
    // All links idle
    link_t [PortCount-1:0] link_i = '1;
    logic [PortCount-1:0]  stop_i = '0;
    link_t [PortCount-1:0] link_o;
    logic [PortCount-1:0]  stop_o;

    stim_t                stim_table [NumEntries];
    flit_t                send_q [PortCount][$];
    expect_t              exp_q [PortCount][$];
    capture_t             got_q [PortCount][$];
    logic [31:0]          acc_q [PortCount][$];
    logic [PortCount-1:0] stop_seen;
    logic [31:0]          cycle = '0;
    logic [31:0]          lcg_state = LcgSeed;
    int                   errors = 0;
    int                   tests_failed = 0;

    lookahead_router i_dut (
        .clk,
        .rst,
        .position_i(position),
        .link_i,
        .stop_i,
        .link_o,
        .stop_o
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    //////////////////////////////////////////////////
    // Link driver and monitor
    //////////////////////////////////////////////////

    // Flit on link_i is taken at an edge where stop_o was low
    always @(posedge clk) begin
        logic taken;
        for (int p = 0; p < PortCount; p++) begin
            if (rst) begin
                link_i[p].is_void <= 1'b1;
                send_q[p].delete();
                acc_q[p].delete();
            end else begin
                taken = !link_i[p].is_void && !stop_o[p];
                if (taken) begin
                    acc_q[p].push_back(cycle);
                end
                if (link_i[p].is_void || taken) begin
                    if (send_q[p].size() > 0) begin
                        link_i[p] <= {send_q[p].pop_front(), 1'b0};
                    end else begin
                        link_i[p].is_void <= 1'b1;
                    end
                end
            end
        end
    end

    // Transfer = void low and stop_i low on the same edge
    always @(posedge clk) begin
        capture_t cap;
        if (rst) begin
            stop_seen <= '0;
            for (int p = 0; p < PortCount; p++) begin
                got_q[p].delete();
            end
        end else begin
            stop_seen <= stop_seen | stop_o;
            for (int p = 0; p < PortCount; p++) begin
                if (!link_o[p].is_void && !stop_i[p]) begin
                    cap.flit  = link_o[p].flit;
                    cap.cycle = cycle;
                    got_q[p].push_back(cap);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Tasks
    //////////////////////////////////////////////////

    task automatic apply_reset();
        @(posedge clk);
        rst    <= 1'b1;
        stop_i <= '0;
        for (int o = 0; o < PortCount; o++) begin
            exp_q[o].delete();
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Sent head routes to out_port, expected head carries the next hop instead
    task automatic load_packet(input stim_t e);
        flit_t   f;
        expect_t x;
        logic    head;
        logic    tail;
        lcg_state = lcg_next(lcg_state ^ e.seed);
        for (int i = 0; i < e.flit_count; i++) begin
            lcg_state = lcg_next(lcg_state);
            head      = (i == 0);
            tail      = (i == e.flit_count - 1);
            f.raw     = {head, tail, lcg_state};
            if (head) begin
                f.header.destination.x = e.dest_x;
                f.header.routing       = direction_t'(1 << e.out_port);
            end
            x.flit      = f;
            x.src       = e.in_port;
            x.check_lat = e.check_lat;
            if (head) begin
                x.flit.header.routing = e.exp_routing;
            end
            send_q[e.in_port].push_back(f);
            exp_q[e.out_port].push_back(x);
        end
    endtask

    task automatic wait_for_delivery(input int t);
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < TimeoutCycles) begin
            @(negedge clk);
            waited++;
            done = 1'b1;
            for (int o = 0; o < PortCount; o++) begin
                if (got_q[o].size() < exp_q[o].size()) begin
                    done = 1'b0;
                end
            end
        end
        if (!done) begin
            for (int o = 0; o < PortCount; o++) begin
                if (got_q[o].size() < exp_q[o].size()) begin
                    $display("Timeout: test %0d received %0d of %0d flits on output %0d in %0d cycles",
                             t, got_q[o].size(), exp_q[o].size(), o, TimeoutCycles);
                    errors++;
                end
            end
        end
        // Late or duplicated flits would land in this window
        repeat (4) @(negedge clk);
    endtask

    task automatic check_delivery();
        int          n;
        logic [31:0] acc;
        for (int o = 0; o < PortCount; o++) begin
            assert (got_q[o].size() == exp_q[o].size()) else begin
                $display("Error: link_o[%0d] flit count exp 0x%0h got 0x%0h",
                         o, exp_q[o].size(), got_q[o].size());
                errors++;
            end
            n = (got_q[o].size() < exp_q[o].size()) ? got_q[o].size() : exp_q[o].size();
            for (int i = 0; i < n; i++) begin
                assert (got_q[o][i].flit.raw == exp_q[o][i].flit.raw) else begin
                    $display("Error: link_o[%0d].flit #%0d exp 0x%h got 0x%h",
                             o, i, exp_q[o][i].flit.raw, got_q[o][i].flit.raw);
                    errors++;
                end
                // Accept times pop in input order, one per delivered flit
                if (acc_q[exp_q[o][i].src].size() > 0) begin
                    acc = acc_q[exp_q[o][i].src].pop_front();
                    if (exp_q[o][i].check_lat) begin
                        assert (got_q[o][i].cycle == acc + 1) else begin
                            $display("Error: link_o[%0d] cycle of flit #%0d exp 0x%0h got 0x%0h",
                                     o, i, acc + 1, got_q[o][i].cycle);
                            errors++;
                        end
                    end
                end
            end
        end
    endtask

    function automatic string test_title(input int t);
        case (t)
            1:       return "single-flit routing";
            2:       return "worm order and latency";
            3:       return "contention on Local";
            4:       return "back-pressure on East";
            default: return "concurrent worms";
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Stimulus table and test loop
    //////////////////////////////////////////////////

    initial begin
        int                   errors_before;
        int                   hold;
        logic [PortCount-1:0] mask;

        stim_table[0] = '{test_id: 4'd1, in_port: PORT_LOCAL, dest_x: 3'd5, flit_count: 4'd1,
            seed: 32'h0000_0011, stop_mask: 3'b000, stop_cycles: 8'd0, out_port: PORT_EAST,
            exp_routing: DirEast, check_lat: 1'b1, expect_stop: 1'b0};
        stim_table[1] = '{test_id: 4'd1, in_port: PORT_WEST, dest_x: 3'd3, flit_count: 4'd1,
            seed: 32'h0000_0022, stop_mask: 3'b000, stop_cycles: 8'd0, out_port: PORT_LOCAL,
            exp_routing: DirNone, check_lat: 1'b1, expect_stop: 1'b0};
        stim_table[2] = '{test_id: 4'd2, in_port: PORT_EAST, dest_x: 3'd0, flit_count: 4'd4,
            seed: 32'h0000_0033, stop_mask: 3'b000, stop_cycles: 8'd0, out_port: PORT_WEST,
            exp_routing: DirWest, check_lat: 1'b1, expect_stop: 1'b0};
        // East listed first, it wins the round-robin
        stim_table[3] = '{test_id: 4'd3, in_port: PORT_EAST, dest_x: 3'd3, flit_count: 4'd3,
            seed: 32'h0000_0044, stop_mask: 3'b000, stop_cycles: 8'd0, out_port: PORT_LOCAL,
            exp_routing: DirNone, check_lat: 1'b0, expect_stop: 1'b0};
        stim_table[4] = '{test_id: 4'd3, in_port: PORT_WEST, dest_x: 3'd3, flit_count: 4'd3,
            seed: 32'h0000_0055, stop_mask: 3'b000, stop_cycles: 8'd0, out_port: PORT_LOCAL,
            exp_routing: DirNone, check_lat: 1'b0, expect_stop: 1'b0};
        stim_table[5] = '{test_id: 4'd4, in_port: PORT_LOCAL, dest_x: 3'd6, flit_count: 4'd8,
            seed: 32'h0000_0066, stop_mask: 3'b001, stop_cycles: 8'd12, out_port: PORT_EAST,
            exp_routing: DirEast, check_lat: 1'b0, expect_stop: 1'b1};
        // Next router is at x = 4, so this one ends there
        stim_table[6] = '{test_id: 4'd5, in_port: PORT_LOCAL, dest_x: 3'd4, flit_count: 4'd5,
            seed: 32'h0000_0077, stop_mask: 3'b000, stop_cycles: 8'd0, out_port: PORT_EAST,
            exp_routing: DirLocal, check_lat: 1'b1, expect_stop: 1'b0};
        stim_table[7] = '{test_id: 4'd5, in_port: PORT_WEST, dest_x: 3'd3, flit_count: 4'd3,
            seed: 32'h0000_0088, stop_mask: 3'b000, stop_cycles: 8'd0, out_port: PORT_LOCAL,
            exp_routing: DirNone, check_lat: 1'b1, expect_stop: 1'b0};

        for (int t = 1; t <= NumTests; t++) begin
            errors_before = errors;
            mask          = '0;
            hold          = 0;
            apply_reset();
            for (int i = 0; i < NumEntries; i++) begin
                if (stim_table[i].test_id == t) begin
                    mask |= stim_table[i].stop_mask;
                    if (stim_table[i].stop_cycles > hold) begin
                        hold = stim_table[i].stop_cycles;
                    end
                end
            end
            @(posedge clk);
            stop_i <= mask;
            // Queues are filled between edges so all packets start together
            @(negedge clk);
            for (int i = 0; i < NumEntries; i++) begin
                if (stim_table[i].test_id == t) begin
                    load_packet(stim_table[i]);
                end
            end
            repeat (hold) @(posedge clk);
            @(posedge clk);
            stop_i <= '0;
            wait_for_delivery(t);
            check_delivery();
            for (int i = 0; i < NumEntries; i++) begin
                if (stim_table[i].test_id == t && stim_table[i].expect_stop) begin
                    assert (stop_seen[stim_table[i].in_port]) else begin
                        $display("Error: stop_o[%0d] exp 0x1 got 0x0 during the whole test",
                                 stim_table[i].in_port);
                        errors++;
                    end
                end
            end
            if (errors == errors_before) begin
                $display("Test %0d %s: ok", t, test_title(t));
            end else begin
                tests_failed++;
                $display("Test %0d %s: FAILED with %0d errors", t, test_title(t),
                         errors - errors_before);
            end
        end

        $display("Tests run %0d, failing %0d, errors %0d", NumTests, tests_failed, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* tb.f */
hw/noc_pkg.sv
hw/router_fifo.sv
hw/router_arbiter.sv
hw/router_input_port.sv
hw/router_output_port.sv
hw/lookahead_router.sv
dv/router_tb.sv

/* Bender.yml */
package:
  name: lookahead_router

sources:
  - files:
      - hw/noc_pkg.sv
      - hw/router_fifo.sv
      - hw/router_arbiter.sv
      - hw/router_input_port.sv
      - hw/router_output_port.sv
      - hw/lookahead_router.sv
  - target: test
    files:
      - dv/router_tb.sv
